// ==== src/video_pkg.sv ====
//##########################################################################
// shared definitions for the video memory subsystem
// sizes, word and address types, host register numbers
// and the ram request struct passed through the arbiter
//##########################################################################

package video_pkg;

    localparam int VRAM_WORDS = 4096;                // ram depth in words
    localparam int ADDR_W     = 12;
    localparam int LINE_WORDS = 8;                   // words per display line
    localparam int LINE_CNT_W = $clog2(LINE_WORDS);

    typedef logic [15:0]       word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [3:0]        mask_t;               // bit n enables nibble n

    // host register numbers
    typedef enum logic [2:0] {
        XR_WR_ADDR   = 3'd0,
        XR_RD_ADDR   = 3'd1,
        XR_INCR      = 3'd2,
        XR_MASK      = 3'd3,
        XR_DATA      = 3'd4,
        XR_LINE_BASE = 3'd5
    } xr_reg_t;

    // one ram access, held stable by the requester until granted
    typedef struct packed {
        logic  sel;
        logic  wr_en;
        mask_t wr_mask;
        addr_t addr;
        word_t data;
    } vram_req_t;

endpackage

// ==== src/vram.sv ====
//##########################################################################
// single port video ram
// nibble write mask, registered read of the old word
//##########################################################################

`timescale 1ns/1ns

module vram import video_pkg::*; (
    input  logic      clk,
    input  vram_req_t ram_req,
    output word_t     rd_data
);

    word_t mem [VRAM_WORDS];

    // ram starts cleared
    initial begin
        for (int i = 0; i < VRAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_req.sel) begin
            if (ram_req.wr_en) begin
                if (ram_req.wr_mask[0]) mem[ram_req.addr][3:0]   <= ram_req.data[3:0];
                if (ram_req.wr_mask[1]) mem[ram_req.addr][7:4]   <= ram_req.data[7:4];
                if (ram_req.wr_mask[2]) mem[ram_req.addr][11:8]  <= ram_req.data[11:8];
                if (ram_req.wr_mask[3]) mem[ram_req.addr][15:12] <= ram_req.data[15:12];
            end
            rd_data <= mem[ram_req.addr];                // old word in a write cycle
        end
    end

    // a write that touches no nibble points at a bad host mask
    a_mask_nonzero: assert property (
        @(posedge clk) (ram_req.sel && ram_req.wr_en) |-> (ram_req.wr_mask != '0)
    ) else $error("vram write with empty nibble mask at addr %h", ram_req.addr);

endmodule

// ==== src/vram_arb.sv ====
//##########################################################################
// fixed priority arbiter for the ram port
// display fetch first, host otherwise
//##########################################################################

`timescale 1ns/1ns

module vram_arb import video_pkg::*; (
    input  vram_req_t host_req,
    input  vram_req_t fetch_req,
    output vram_req_t ram_req,
    output logic      host_grant,
    output logic      fetch_grant
);

    logic pick_fetch;

    assign pick_fetch = fetch_req.sel;

    always_comb begin
        if (pick_fetch) begin
            ram_req = fetch_req;
        end else begin
            ram_req = host_req;             // sel low here when host is idle too
        end
    end

    // grants mark the cycle the access reaches the ram
    assign fetch_grant = pick_fetch;
    assign host_grant  = host_req.sel && !pick_fetch;

endmodule

// ==== src/host_regs.sv ====
//##########################################################################
// host register file for video memory access
// write/read addresses with auto increment, nibble mask,
// posted data writes, read prefetch and the display line base
//##########################################################################

`timescale 1ns/1ns

module host_regs import video_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  xr_reg_t   reg_num,
    input  word_t     reg_wdata,
    output word_t     reg_rdata,
    output logic      busy,
    output addr_t     line_base,
    output vram_req_t host_req,
    input  logic      host_grant,
    input  word_t     rd_data
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,      // posted write waiting for the port
        READ,       // prefetch waiting for the port
        LATCH       // ram data returns this cycle
    } host_state_t;

    host_state_t state;
    addr_t       wr_addr;
    addr_t       rd_addr;
    addr_t       incr;
    mask_t       mask;
    word_t       wr_data;       // pending write word
    word_t       rd_latch;      // prefetched word for XR_DATA reads

    logic data_wr;
    logic data_rd;

    assign data_wr = reg_wr && (reg_num == XR_DATA);
    assign data_rd = reg_rd && (reg_num == XR_DATA);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            wr_addr   <= '0;
            rd_addr   <= '0;
            incr      <= addr_t'(1);
            mask      <= '1;
            line_base <= '0;
            rd_latch  <= '0;
        end else begin
            if (reg_wr) begin
                case (reg_num)
                    XR_WR_ADDR:   wr_addr   <= reg_wdata[ADDR_W-1:0];
                    XR_INCR:      incr      <= reg_wdata[ADDR_W-1:0];
                    XR_MASK:      mask      <= reg_wdata[3:0];
                    XR_LINE_BASE: line_base <= reg_wdata[ADDR_W-1:0];
                    default: ;
                endcase
            end

            case (state)
                IDLE: begin
                    if (data_wr) begin
                        state <= WRITE;
                    end else if (reg_wr && reg_num == XR_RD_ADDR) begin
                        rd_addr <= reg_wdata[ADDR_W-1:0];
                        state   <= READ;
                    end else if (data_rd) begin
                        rd_addr <= rd_addr + incr;          // wraps at VRAM_WORDS
                        state   <= READ;
                    end
                end
                WRITE: begin
                    if (host_grant) begin
                        wr_addr <= wr_addr + incr;
                        state   <= IDLE;
                    end
                end
                READ: begin
                    if (host_grant) state <= LATCH;
                end
                LATCH: begin
                    rd_latch <= rd_data;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // write payload, captured when the write is posted
    always_ff @(posedge clk) begin
        if (data_wr && state == IDLE) wr_data <= reg_wdata;
    end

    assign busy = (state != IDLE);

    always_comb begin
        host_req.sel     = (state == WRITE) || (state == READ);
        host_req.wr_en   = (state == WRITE);
        host_req.wr_mask = mask;
        host_req.addr    = (state == WRITE) ? wr_addr : rd_addr;
        host_req.data    = wr_data;
    end

    always_comb begin
        case (reg_num)
            XR_WR_ADDR:   reg_rdata = word_t'(wr_addr);
            XR_RD_ADDR:   reg_rdata = word_t'(rd_addr);
            XR_INCR:      reg_rdata = word_t'(incr);
            XR_MASK:      reg_rdata = word_t'(mask);
            XR_DATA:      reg_rdata = rd_latch;
            XR_LINE_BASE: reg_rdata = word_t'(line_base);
            default:      reg_rdata = '0;
        endcase
    end

    // data port accesses only between transfers
    a_data_not_busy: assert property (
        @(posedge clk) disable iff (rst) (data_wr || data_rd) |-> !busy
    ) else $error("XR_DATA strobed while busy");

endmodule

// ==== src/line_fetch.sv ====
//##########################################################################
// display line fetch
// reads LINE_WORDS words from line_base after each line_start
//##########################################################################

`timescale 1ns/1ns

module line_fetch import video_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      line_start,
    input  addr_t     line_base,
    output vram_req_t fetch_req,
    input  word_t     rd_data,
    output word_t     pix_word,
    output logic      pix_valid
);

    logic                  active;
    logic [LINE_CNT_W-1:0] word_cnt;
    addr_t                 fetch_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            word_cnt   <= '0;
            fetch_addr <= '0;
        end else if (active) begin
            fetch_addr <= fetch_addr + addr_t'(1);      // wraps at end of ram
            word_cnt   <= word_cnt + 1'b1;
            if (word_cnt == LINE_CNT_W'(LINE_WORDS - 1)) begin
                active <= 1'b0;
            end
        end else if (line_start) begin                  // ignored mid line
            active     <= 1'b1;
            word_cnt   <= '0;
            fetch_addr <= line_base;
        end
    end

    always_comb begin
        fetch_req.sel     = active;
        fetch_req.wr_en   = 1'b0;
        fetch_req.wr_mask = '0;
        fetch_req.addr    = fetch_addr;
        fetch_req.data    = '0;
    end

    // fetch always wins the port, so sel doubles as the grant
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= active;
        end
    end

    assign pix_word = rd_data;      // ram output register holds the word

endmodule

// ==== src/video_top.sv ====
//##########################################################################
// video memory subsystem top
// host registers, line fetch, arbiter and video ram
//##########################################################################

`timescale 1ns/1ns

module video_top import video_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    reg_wr,
    input  logic    reg_rd,
    input  xr_reg_t reg_num,
    input  word_t   reg_wdata,
    output word_t   reg_rdata,
    output logic    busy,
    input  logic    line_start,
    output word_t   pix_word,
    output logic    pix_valid
);

    vram_req_t host_req;
    vram_req_t fetch_req;
    vram_req_t ram_req;
    logic      host_grant;
    addr_t     line_base;
    word_t     rd_data;

    host_regs host_regs_i (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_num    (reg_num),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .busy       (busy),
        .line_base  (line_base),
        .host_req   (host_req),
        .host_grant (host_grant),
        .rd_data    (rd_data)
    );

    line_fetch line_fetch_i (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .line_base  (line_base),
        .fetch_req  (fetch_req),
        .rd_data    (rd_data),
        .pix_word   (pix_word),
        .pix_valid  (pix_valid)
    );

    // fetch never waits for the port
    vram_arb vram_arb_i (
        .host_req    (host_req),
        .fetch_req   (fetch_req),
        .ram_req     (ram_req),
        .host_grant  (host_grant),
        .fetch_grant ()
    );

    vram vram_i (
        .clk     (clk),
        .ram_req (ram_req),
        .rd_data (rd_data)
    );

endmodule

// ==== tests/video_tb.sv ====
//##########################################################################
// testbench for the video memory subsystem
// step table built against a memory model, line fetch monitor,
// value check task and cycle watchdog
//##########################################################################

`timescale 1ns/1ns

module video_tb import video_pkg::*; ();

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_LINE, OP_WAIT} op_t;

    typedef struct packed {
        op_t        op;
        xr_reg_t    num;
        word_t      data;       // write data, or base for a line step
        word_t      exp;        // expected reg_rdata on a read step
        logic [2:0] test;
    } step_t;

    logic    clk;
    logic    rst;
    logic    reg_wr;
    logic    reg_rd;
    xr_reg_t reg_num;
    word_t   reg_wdata;
    word_t   reg_rdata;
    logic    busy;
    logic    line_start;
    word_t   pix_word;
    logic    pix_valid;

    step_t       steps[$];
    word_t       pix_exp[$];             // words the next line fetches must show
    word_t       model_mem [VRAM_WORDS];
    addr_t       m_wr;
    addr_t       m_rd;
    addr_t       m_incr;
    addr_t       m_base;
    mask_t       m_mask;
    logic [2:0]  cur_test;
    logic [31:0] lcg_state = 32'ha41;
    int          errors = 0;
    int          checks = 0;
    int          pix_left = 0;
    int          cycles = 0;
    int          limit_cycles = 1000;
    string       test_name [5] = '{"reset", "sequential", "masked", "line fetch", "contention"};

    video_top video_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit_cycles) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_val(input string sig, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, sig, exp, got);
        end
    endtask

    // pix_word is the ram output register, steady at the falling edge
    always @(negedge clk) begin
        if (!rst && pix_valid) begin
            if (pix_left == 0) begin
                errors++;
                $display("pix_valid strobe at %0t ns with no line fetch pending", $time);
            end else begin
                check_val("pix_word", pix_word, pix_exp.pop_front());
                pix_left--;
            end
        end
    end

    function automatic word_t lcg_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:8];
    endfunction

    function automatic void add_wr(xr_reg_t num, word_t data);
        word_t w;
        steps.push_back('{OP_WR, num, data, 16'h0, cur_test});
        case (num)
            XR_WR_ADDR: m_wr = data[ADDR_W-1:0];
            XR_RD_ADDR: m_rd = data[ADDR_W-1:0];
            XR_INCR:    m_incr = data[ADDR_W-1:0];
            XR_MASK:    m_mask = data[3:0];
            XR_DATA: begin
                w = model_mem[m_wr];
                for (int n = 0; n < 4; n++) begin
                    if (m_mask[n]) w[4*n +: 4] = data[4*n +: 4];   // only enabled nibbles
                end
                model_mem[m_wr] = w;
                m_wr = m_wr + m_incr;           // 12 bit add wraps like the ram
            end
            default: ;
        endcase
    endfunction

    function automatic void add_rd();
        steps.push_back('{OP_RD, XR_DATA, 16'h0, model_mem[m_rd], cur_test});
        m_rd = m_rd + m_incr;
    endfunction

    function automatic void add_line(word_t base);
        m_base = base[ADDR_W-1:0];
        steps.push_back('{OP_LINE, XR_LINE_BASE, base, 16'h0, cur_test});
        for (int i = 0; i < LINE_WORDS; i++) begin
            pix_exp.push_back(model_mem[m_base + addr_t'(i)]);
        end
    endfunction

    function automatic void build_table();
        mask_t masks [8] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h6, 4'h9, 4'h3, 4'hc};
        foreach (model_mem[i]) model_mem[i] = '0;
        m_wr = '0;
        m_rd = '0;
        m_incr = addr_t'(1);
        m_mask = '1;
        m_base = '0;
        cur_test = 3'd0;
        add_rd();                               // cleared latch and ram
        cur_test = 3'd1;
        add_wr(XR_WR_ADDR, 16'h010);
        for (int i = 0; i < 6; i++) add_wr(XR_DATA, lcg_word());
        add_wr(XR_RD_ADDR, 16'h010);
        for (int i = 0; i < 6; i++) add_rd();
        add_wr(XR_INCR, 16'd3);
        add_wr(XR_WR_ADDR, 16'h200);
        for (int i = 0; i < 6; i++) add_wr(XR_DATA, lcg_word());
        add_wr(XR_RD_ADDR, 16'h200);
        for (int i = 0; i < 6; i++) add_rd();
        cur_test = 3'd2;
        add_wr(XR_INCR, 16'd1);
        add_wr(XR_WR_ADDR, 16'h040);
        for (int i = 0; i < 8; i++) add_wr(XR_DATA, lcg_word());
        add_wr(XR_WR_ADDR, 16'h040);
        foreach (masks[i]) begin
            add_wr(XR_MASK, word_t'(masks[i]));
            add_wr(XR_DATA, lcg_word());
        end
        add_wr(XR_MASK, 16'hf);
        add_wr(XR_RD_ADDR, 16'h040);
        for (int i = 0; i < 8; i++) add_rd();
        cur_test = 3'd3;
        add_wr(XR_WR_ADDR, 16'hffc);            // run crosses the top of ram
        for (int i = 0; i < 8; i++) add_wr(XR_DATA, lcg_word());
        add_line(16'hffc);
        steps.push_back('{OP_WAIT, XR_DATA, 16'h0, 16'h0, cur_test});
        cur_test = 3'd4;
        add_wr(XR_WR_ADDR, 16'h100);
        for (int i = 0; i < 8; i++) add_wr(XR_DATA, lcg_word());
        add_wr(XR_WR_ADDR, 16'h103);
        add_line(16'h100);
        add_wr(XR_DATA, lcg_word());            // lands after the line is read
        steps.push_back('{OP_WAIT, XR_DATA, 16'h0, 16'h0, cur_test});
        add_wr(XR_RD_ADDR, 16'h103);
        add_rd();
    endfunction

    task automatic wait_ready(input logic for_line);
        while (busy || (for_line && pix_left != 0)) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic reg_write(input xr_reg_t num, input word_t data);
        reg_wr = 1'b1;
        reg_num = num;
        reg_wdata = data;
        @(posedge clk);
        #2;
        reg_wr = 1'b0;
    endtask

    initial begin
        step_t s;
        int    n;
        int    test_err;
        rst = 1'b1;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_num = XR_WR_ADDR;
        reg_wdata = '0;
        line_start = 1'b0;
        build_table();
        limit_cycles = 20 * steps.size() + 200;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        test_err = errors;
        check_val("busy", word_t'(busy), 16'h0);
        check_val("pix_valid", word_t'(pix_valid), 16'h0);
        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            case (s.op)
                OP_WR: begin
                    wait_ready(1'b0);
                    reg_write(s.num, s.data);
                    n = 0;
                    while (s.num == XR_DATA && busy && n < LINE_WORDS + 2) begin
                        @(posedge clk);
                        #2;
                        n++;
                    end
                    if (busy && s.num == XR_DATA) begin
                        errors++;
                        $display("busy still high %0d cycles after a data write", n);
                    end
                end
                OP_RD: begin
                    wait_ready(1'b0);
                    reg_rd = 1'b1;
                    reg_num = XR_DATA;
                    #8;
                    check_val("reg_rdata", reg_rdata, s.exp);
                    @(posedge clk);
                    #2;
                    reg_rd = 1'b0;
                end
                OP_LINE: begin
                    wait_ready(1'b1);
                    reg_write(XR_LINE_BASE, s.data);
                    line_start = 1'b1;
                    pix_left = LINE_WORDS;
                    @(posedge clk);
                    #2;
                    line_start = 1'b0;
                end
                default: wait_ready(1'b1);
            endcase
            if (i == steps.size() - 1 || steps[i+1].test != s.test) begin
                $display("test %0d %s done, %0d errors", s.test + 1, test_name[s.test],
                         errors - test_err);
                test_err = errors;
            end
        end
        if (pix_exp.size() != 0) begin
            errors++;
            $display("%0d expected line words never arrived", pix_exp.size());
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/video_pkg.sv
src/vram.sv
src/vram_arb.sv
src/host_regs.sv
src/line_fetch.sv
src/video_top.sv
tests/video_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the video memory testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module video_tb \
    -o video_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/video_sim > sim.log 2>&1
cat sim.log
# a logged failure decides the status, a missing pass line fails too
grep -qF '** FAIL **' sim.log && exit 1 || grep -qF '** PASS **' sim.log
